// File: design/radio_ctrl_params.svh
// Settings bus map, reset values and readback indices; include in any RTL that decodes them
`ifndef RADIO_CTRL_PARAMS_SVH
`define RADIO_CTRL_PARAMS_SVH

////////////////////
// Settings bus bases

// Seven misc regs, offsets 0..6
// clock, serdes, adc, led_sw, phy_reset, bldr_done, led_src
`define SR_MISC            0
`define SR_TIME64          10          // High word here, low word at +1 loads

////////////////////
// Reset values

`define LED_SRC_AT_RESET   8'h1E       // LEDs 1 to 4 on hardware status
`define COMPAT_NUM         32'h0008_0002  // Major 8, minor 2

////////////////////
// Readback word indices

`define RB_VITA_HI         10
`define RB_VITA_LO         11
`define RB_COMPAT          12
`define RB_STATUS          13
`define RB_PPS_HI          14
`define RB_PPS_LO          15

`endif

// File: design/radio_ctrl_pkg.sv
// Shared bus and control types for the radio control plane; import where the types are used
package radio_ctrl_pkg;

   ////////////////////
   // Settings bus

   // One write per cycle while stb is high
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   ////////////////////
   // Control line groups

   typedef struct packed {
      logic       clock_ready;   // Bit 4
      logic [1:0] clk_en;
      logic [1:0] clk_sel;       // Bits 1:0
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;              // Bit 3
      logic prbsen;
      logic loopen;
      logic rx_en;               // Bit 0
   } serdes_ctrl_t;

   // Output enable and power per ADC channel
   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef logic [7:0]  led_vec_t;    // One bit per LED
   typedef logic [63:0] vita_time_t;  // Ticks of dsp_clk
   typedef logic [31:0] rb_word_t;
   typedef logic [3:0]  rb_index_t;

endpackage

// File: design/boot_ctrl_fsm.sv
// Bootloader reset sequencer; holds core reset after power-on and pulses it once on bldr_done
`timescale 1ns/1ps

module boot_ctrl_fsm (
   input  logic dsp_clk,
   input  logic por_rst,
   input  logic bldr_done_i,   // Written by the bootloader
   output logic core_rst_o,
   output logic boot_map_o     // High while boot memory is mapped low
);

   typedef enum logic {
      ST_WAIT = 1'b0,
      ST_DONE = 1'b1
   } boot_state_t;

   boot_state_t state_q;
   logic        core_rst_q;
   logic        boot_map_q;

   ////////////////////
   // State machine

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state_q    <= ST_WAIT;
         core_rst_q <= 1'b1;
         boot_map_q <= 1'b1;
      end else begin
         case (state_q)
            ST_WAIT: begin
               core_rst_q <= 1'b0;          // Release after power-on
               if (bldr_done_i) begin
                  state_q    <= ST_DONE;
                  core_rst_q <= 1'b1;       // One-cycle restart pulse
                  boot_map_q <= 1'b0;       // Swap to main memory
               end
            end
            ST_DONE: begin
               // Parked here until the next power-on reset
               core_rst_q <= 1'b0;
            end
         endcase
      end
   end

   assign core_rst_o = core_rst_q;
   assign boot_map_o = boot_map_q;

endmodule

// File: design/vita_time_counter.sv
// Loadable 64-bit VITA time counter with PPS capture; written through the settings bus
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module vita_time_counter
   import radio_ctrl_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       rst_i,
   input  set_bus_t   set_bus_i,
   input  logic       pps_i,            // Asynchronous
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       good_sync_o
);

   localparam logic [7:0] ADDR_TIME_HI = 8'(`SR_TIME64);
   localparam logic [7:0] ADDR_TIME_LO = 8'(`SR_TIME64 + 1);

   logic [31:0] time_hi_q;
   logic        load_hi;
   logic        load_lo;
   logic [2:0]  pps_sync_q;
   logic        pps_rise;
   vita_time_t  time_q;
   vita_time_t  time_pps_q;
   logic        good_sync_q;

   assign load_hi = set_bus_i.stb && (set_bus_i.addr == ADDR_TIME_HI);
   assign load_lo = set_bus_i.stb && (set_bus_i.addr == ADDR_TIME_LO);

   // Upper half waits here for the low-word write
   always_ff @(posedge dsp_clk) begin
      if (load_hi) begin
         time_hi_q <= set_bus_i.data;
      end
   end

   ////////////////////
   // PPS synchronizer

   // Two sync stages, third stage for the edge
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         pps_sync_q <= '0;
      end else begin
         pps_sync_q <= {pps_sync_q[1:0], pps_i};
      end
   end

   assign pps_rise = pps_sync_q[1] & ~pps_sync_q[2];

   ////////////////////
   // Counter

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         time_q      <= '0;
         good_sync_q <= 1'b0;
      end else if (load_lo) begin
         time_q      <= {time_hi_q, set_bus_i.data};
         good_sync_q <= 1'b0;                  // New epoch, not yet locked to PPS
      end else begin
         time_q <= time_q + 64'd1;
         if (pps_rise) begin
            good_sync_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (pps_rise) begin
         time_pps_q <= time_q;                 // Time of last PPS edge
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = time_pps_q;
   assign good_sync_o     = good_sync_q;

endmodule

// File: design/misc_settings_bank.sv
// Misc settings registers and LED source mux; decodes the SR_MISC block of the settings bus
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module misc_settings_bank
   import radio_ctrl_pkg::*;
(
   input  logic         dsp_clk,
   input  logic         rst_i,
   input  set_bus_t     set_bus_i,
   input  logic         clk_status_i,
   input  logic         serdes_link_up_i,
   input  logic         good_sync_i,
   input  logic         run_rx_i,
   input  logic         run_tx_i,
   output clock_ctrl_t  clock_ctrl_o,
   output serdes_ctrl_t serdes_ctrl_o,
   output adc_ctrl_t    adc_ctrl_o,
   output logic         phy_reset_n_o,
   output logic         bldr_done_o,
   output led_vec_t     leds_o
);

   ////////////////////
   // Register map

   localparam logic [7:0] ADDR_CLOCK   = 8'(`SR_MISC + 0);
   localparam logic [7:0] ADDR_SERDES  = 8'(`SR_MISC + 1);
   localparam logic [7:0] ADDR_ADC     = 8'(`SR_MISC + 2);
   localparam logic [7:0] ADDR_LED_SW  = 8'(`SR_MISC + 3);
   localparam logic [7:0] ADDR_PHY     = 8'(`SR_MISC + 4);
   localparam logic [7:0] ADDR_BLDR    = 8'(`SR_MISC + 5);
   localparam logic [7:0] ADDR_LED_SRC = 8'(`SR_MISC + 6);

   clock_ctrl_t  clock_q;
   serdes_ctrl_t serdes_q;
   adc_ctrl_t    adc_q;
   led_vec_t     led_sw_q;
   led_vec_t     led_src_q;      // 1 = hardware, 0 = software
   logic         phy_reset_q;
   logic         bldr_done_q;
   led_vec_t     led_hw;

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         clock_q     <= '0;
         serdes_q    <= '0;
         adc_q       <= '0;
         led_sw_q    <= '0;
         led_src_q   <= `LED_SRC_AT_RESET;
         phy_reset_q <= 1'b0;
         bldr_done_q <= 1'b0;
      end else if (set_bus_i.stb) begin
         // Only the low bits of each word are kept
         case (set_bus_i.addr)
            ADDR_CLOCK:   clock_q     <= set_bus_i.data[$bits(clock_ctrl_t)-1:0];
            ADDR_SERDES:  serdes_q    <= set_bus_i.data[$bits(serdes_ctrl_t)-1:0];
            ADDR_ADC:     adc_q       <= set_bus_i.data[$bits(adc_ctrl_t)-1:0];
            ADDR_LED_SW:  led_sw_q    <= set_bus_i.data[7:0];
            ADDR_PHY:     phy_reset_q <= set_bus_i.data[0];
            ADDR_BLDR:    bldr_done_q <= set_bus_i.data[0];
            ADDR_LED_SRC: led_src_q   <= set_bus_i.data[7:0];
            default: begin
            end
         endcase
      end
   end

   ////////////////////
   // LED source mux

   // Top three LEDs and LED 0 have no hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   assign clock_ctrl_o  = clock_q;
   assign serdes_ctrl_o = serdes_q;
   assign adc_ctrl_o    = adc_q;
   assign phy_reset_n_o = ~phy_reset_q;   // PHY reset pin is active low
   assign bldr_done_o   = bldr_done_q;

endmodule

// File: design/status_readback_mux.sv
// Registered 16-word status readback; the word for rb_index_i appears one cycle later
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module status_readback_mux
   import radio_ctrl_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       rst_i,
   input  rb_index_t  rb_index_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   input  logic       button_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   output rb_word_t   rb_data_o
);

   rb_word_t status_word;
   rb_word_t rb_next;
   rb_word_t rb_q;

   // Button at 13, clock status at 11, link at 10
   assign status_word = {18'd0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'd0};

   always_comb begin
      case (rb_index_i)
         4'(`RB_VITA_HI): rb_next = vita_time_i[63:32];
         4'(`RB_VITA_LO): rb_next = vita_time_i[31:0];
         4'(`RB_COMPAT):  rb_next = `COMPAT_NUM;
         4'(`RB_STATUS):  rb_next = status_word;
         4'(`RB_PPS_HI):  rb_next = vita_time_pps_i[63:32];
         4'(`RB_PPS_LO):  rb_next = vita_time_pps_i[31:0];
         default:         rb_next = '0;       // Words 0 to 9 unused here
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         rb_q <= '0;
      end else begin
         rb_q <= rb_next;
      end
   end

   assign rb_data_o = rb_q;

endmodule

// File: design/radio_ctrl_core.sv
// Radio control plane top level; connects boot sequencer, settings bank, time counter, readback
`timescale 1ns/1ps

module radio_ctrl_core
   import radio_ctrl_pkg::*;
(
   input  logic         dsp_clk,
   input  logic         por_rst,
   input  set_bus_t     set_bus_i,
   input  logic         pps_i,
   input  logic         button_i,
   input  logic         clk_status_i,
   input  logic         serdes_link_up_i,
   input  logic         run_rx_i,
   input  logic         run_tx_i,
   input  rb_index_t    rb_index_i,
   output rb_word_t     rb_data_o,
   output clock_ctrl_t  clock_ctrl_o,
   output serdes_ctrl_t serdes_ctrl_o,
   output adc_ctrl_t    adc_ctrl_o,
   output logic         phy_reset_n_o,
   output led_vec_t     leds_o,
   output logic         core_rst_o,     // Reset of everything but the boot FSM
   output logic         boot_map_o
);

   logic       bldr_done;
   logic       good_sync;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   ////////////////////
   // Reset sequencing

   boot_ctrl_fsm boot_ctrl_fsm_inst (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .core_rst_o  (core_rst_o),
      .boot_map_o  (boot_map_o)
   );

   ////////////////////
   // Settings consumers

   misc_settings_bank misc_settings_bank_inst (
      .dsp_clk          (dsp_clk),
      .rst_i            (core_rst_o),
      .set_bus_i        (set_bus_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .good_sync_i      (good_sync),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .clock_ctrl_o     (clock_ctrl_o),
      .serdes_ctrl_o    (serdes_ctrl_o),
      .adc_ctrl_o       (adc_ctrl_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .bldr_done_o      (bldr_done),
      .leds_o           (leds_o)
   );

   vita_time_counter vita_time_counter_inst (
      .dsp_clk         (dsp_clk),
      .rst_i           (core_rst_o),
      .set_bus_i       (set_bus_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .good_sync_o     (good_sync)
   );

   ////////////////////
   // Readback

   status_readback_mux status_readback_mux_inst (
      .dsp_clk          (dsp_clk),
      .rst_i            (core_rst_o),
      .rb_index_i       (rb_index_i),
      .vita_time_i      (vita_time),
      .vita_time_pps_i  (vita_time_pps),
      .button_i         (button_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .rb_data_o        (rb_data_o)
   );

endmodule

// File: tests/radio_ctrl_core_assertions.sv
// Bound checks on power-on and bootloader reset behavior; bind onto the radio control top level
`timescale 1ns/1ps

module radio_ctrl_core_assertions (
   input logic dsp_clk,
   input logic por_rst,
   input logic core_rst_i,
   input logic boot_map_i,
   input logic phy_reset_n_i
);

   int unsigned fail_count = 0;   // Polled by the testbench

   // Core reset is a single-cycle pulse once power-on reset is gone
   core_rst_single_pulse: assert property (@(posedge dsp_clk)
      (core_rst_i && !por_rst) |=> !core_rst_i)
   else begin
      fail_count++;
      $error("core_rst_o stayed high for two cycles outside por_rst");
   end

   boot_map_drop_with_reset: assert property (@(posedge dsp_clk)
      $fell(boot_map_i) |-> $rose(core_rst_i))
   else begin
      fail_count++;
      $error("boot_map_o fell without a rising core_rst_o");
   end

   // Bank reset puts the PHY pin back to its released level
   phy_released_after_reset: assert property (@(posedge dsp_clk)
      core_rst_i |=> phy_reset_n_i)
   else begin
      fail_count++;
      $error("phy_reset_n_o low in the cycle after core_rst_o");
   end

endmodule

bind radio_ctrl_core radio_ctrl_core_assertions radio_ctrl_core_assertions_inst (
   .dsp_clk       (dsp_clk),
   .por_rst       (por_rst),
   .core_rst_i    (core_rst_o),
   .boot_map_i    (boot_map_o),
   .phy_reset_n_i (phy_reset_n_o)
);

// File: tests/radio_ctrl_core_tb.sv
// Directed testbench for the radio control plane; run it as the simulation top from the file list
`timescale 1ns/1ps
`include "radio_ctrl_params.svh"

module radio_ctrl_core_tb
   import radio_ctrl_pkg::*;
();

   localparam int RESET_CYCLES    = 5;
   localparam int TEST_CYCLES     = RESET_CYCLES + 3 * 17 + 3 * 6 + 20;  // Writes, reads, waits
   localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

   logic         dsp_clk = 1'b0;
   logic         por_rst;
   set_bus_t     set_bus_i;
   logic         pps_i;
   logic         button_i, clk_status_i, serdes_link_up_i, run_rx_i, run_tx_i;
   rb_index_t    rb_index_i;
   rb_word_t     rb_data_o;
   clock_ctrl_t  clock_ctrl_o;
   serdes_ctrl_t serdes_ctrl_o;
   adc_ctrl_t    adc_ctrl_o;
   logic         phy_reset_n_o, core_rst_o, boot_map_o;
   led_vec_t     leds_o;
   int unsigned  cycle_cnt = 0;    // Rising edges seen so far
   vita_time_t   time_base;        // Loaded time
   int unsigned  base_edge;        // Edge count at the load

   radio_ctrl_core radio_ctrl_core_inst (.*);

   always #5 dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk) cycle_cnt <= cycle_cnt + 1;

   ////////////////////
   // Failure handling

   task automatic end_with_failure();
      $display("*** FAILED ***");
      $fatal(1, "Run stopped at the first error");
   endtask

   always @(negedge dsp_clk) begin
      if (radio_ctrl_core_inst.radio_ctrl_core_assertions_inst.fail_count != 0) begin
         $display("A bound assertion on reset or boot behavior failed");
         end_with_failure();
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge dsp_clk);
      $display("Watchdog expired before the tests finished");
      end_with_failure();
   end

   task automatic compare_word(input string name, input rb_word_t got, input rb_word_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_leds(input led_vec_t got, input led_vec_t exp);
      if (got !== exp) begin
         $display("[FAIL] leds_o got 0x%h expected 0x%h", got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_clock(input clock_ctrl_t got, input clock_ctrl_t exp);
      if (got !== exp) begin
         $display("[FAIL] clock_ctrl_o got 0x%h expected 0x%h", got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_serdes(input serdes_ctrl_t got, input serdes_ctrl_t exp);
      if (got !== exp) begin
         $display("[FAIL] serdes_ctrl_o got 0x%h expected 0x%h", got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_adc(input adc_ctrl_t got, input adc_ctrl_t exp);
      if (got !== exp) begin
         $display("[FAIL] adc_ctrl_o got 0x%h expected 0x%h", got, exp);
         end_with_failure();
      end
   endtask

   ////////////////////
   // Bus helpers

   // Per LED, hardware bit where src is set
   function automatic led_vec_t expected_leds(input led_vec_t src, input led_vec_t sw,
                                              input logic sync);
      led_vec_t hw;
      led_vec_t result;
      hw = 8'h00;
      hw[4] = run_tx_i;
      hw[3] = run_rx_i;
      hw[2] = clk_status_i;
      hw[1] = serdes_link_up_i & sync;
      for (int i = 0; i < 8; i++) begin
         result[i] = src[i] ? hw[i] : sw[i];
      end
      return result;
   endfunction

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge dsp_clk);
      set_bus_i <= {1'b1, addr, data};
      @(posedge dsp_clk);                   // Sampling edge
      set_bus_i <= '0;
   endtask

   // Index goes out at sel_edge, word is captured one edge later
   task automatic read_word(input rb_index_t idx, output rb_word_t word,
                            output int unsigned sel_edge);
      @(posedge dsp_clk);
      rb_index_i <= idx;
      sel_edge = cycle_cnt;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      word = rb_data_o;
   endtask

   ////////////////////
   // Directed tests

   task automatic check_reset_defaults();
      rb_word_t    word;
      int unsigned sel;
      // Hardware status high so the reset LED source mask shows
      {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i} <= 4'b1111;
      while (core_rst_o !== 1'b0) @(negedge dsp_clk);
      compare_clock(clock_ctrl_o, '0);
      compare_serdes(serdes_ctrl_o, '0);
      compare_adc(adc_ctrl_o, '0);
      compare_bit("phy_reset_n_o", phy_reset_n_o, 1'b1);
      compare_bit("boot_map_o", boot_map_o, 1'b1);
      compare_leds(leds_o, expected_leds(`LED_SRC_AT_RESET, 8'h00, 1'b0));
      read_word(4'(`RB_COMPAT), word, sel);
      compare_word("rb_data_o (compat)", word, `COMPAT_NUM);
   endtask

   task automatic write_misc_regs();
      logic [31:0] data;
      data = $urandom();
      write_setting(8'(`SR_MISC + 0), data);
      @(negedge dsp_clk);
      compare_clock(clock_ctrl_o, data[4:0]);
      data = $urandom();
      write_setting(8'(`SR_MISC + 1), data);
      @(negedge dsp_clk);
      compare_serdes(serdes_ctrl_o, data[3:0]);
      data = $urandom();
      write_setting(8'(`SR_MISC + 2), data);
      @(negedge dsp_clk);
      compare_adc(adc_ctrl_o, data[3:0]);
      data = $urandom();
      write_setting(8'(`SR_MISC + 4), data);
      @(negedge dsp_clk);
      compare_bit("phy_reset_n_o", phy_reset_n_o, ~data[0]);
   endtask

   task automatic select_led_sources();
      led_vec_t sw;
      led_vec_t src;
      repeat (4) begin
         sw  = 8'($urandom());
         src = 8'($urandom());
         write_setting(8'(`SR_MISC + 3), 32'(sw));
         write_setting(8'(`SR_MISC + 6), 32'(src));
         {run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i} <= 4'($urandom());
         @(negedge dsp_clk);
         compare_leds(leds_o, expected_leds(src, sw, 1'b0));   // No PPS seen yet
      end
      write_setting(8'(`SR_MISC + 6), 32'h0);
      @(negedge dsp_clk);
      compare_leds(leds_o, sw);             // All software
   endtask

   task automatic load_time_and_read();
      rb_word_t    word;
      int unsigned sel;
      vita_time_t  exp;
      time_base = {32'($urandom()), 32'hFFFF_FFF8};   // Low word wraps within the test
      write_setting(8'(`SR_TIME64), time_base[63:32]);
      write_setting(8'(`SR_TIME64 + 1), time_base[31:0]);
      base_edge = cycle_cnt;
      read_word(4'(`RB_VITA_LO), word, sel);
      exp = time_base + 64'(sel - base_edge);
      compare_word("rb_data_o (time low)", word, exp[31:0]);
      repeat (6) @(posedge dsp_clk);
      read_word(4'(`RB_VITA_HI), word, sel);
      exp = time_base + 64'(sel - base_edge);
      compare_word("rb_data_o (time high)", word, exp[63:32]);
   endtask

   task automatic capture_pps();
      rb_word_t    hi_word;
      rb_word_t    lo_word;
      int unsigned sel;
      int unsigned pulse_edge;
      vita_time_t  at_pulse;
      vita_time_t  captured;
      @(posedge dsp_clk);
      pps_i <= 1'b1;
      {button_i, clk_status_i, serdes_link_up_i} <= 3'($urandom());
      pulse_edge = cycle_cnt;
      repeat (4) @(posedge dsp_clk);
      pps_i <= 1'b0;
      read_word(4'(`RB_PPS_HI), hi_word, sel);
      read_word(4'(`RB_PPS_LO), lo_word, sel);
      captured = {hi_word, lo_word};
      at_pulse = time_base + 64'(pulse_edge - base_edge);
      if (captured < at_pulse || captured > at_pulse + 64'd6) begin
         $display("[FAIL] vita_time_pps got 0x%h expected 0x%h to 0x%h",
                  captured, at_pulse, at_pulse + 64'd6);
         end_with_failure();
      end
      read_word(4'(`RB_STATUS), lo_word, sel);
      compare_word("rb_data_o (status)", lo_word, (32'(button_i) << 13) |
                   (32'(clk_status_i) << 11) | (32'(serdes_link_up_i) << 10));
   endtask

   task automatic pulse_bootloader_reset();
      write_setting(8'(`SR_MISC + 0), 32'h1F);        // Non-default so the reset shows
      write_setting(8'(`SR_MISC + 4), 32'h1);         // PHY held in reset
      write_setting(8'(`SR_MISC + 5), 32'h1);
      @(negedge dsp_clk);
      compare_bit("core_rst_o", core_rst_o, 1'b0);
      @(negedge dsp_clk);
      compare_bit("core_rst_o", core_rst_o, 1'b1);
      compare_bit("boot_map_o", boot_map_o, 1'b0);
      @(negedge dsp_clk);
      compare_bit("core_rst_o", core_rst_o, 1'b0);
      compare_clock(clock_ctrl_o, '0);
      compare_serdes(serdes_ctrl_o, '0);
      compare_adc(adc_ctrl_o, '0);
      compare_bit("phy_reset_n_o", phy_reset_n_o, 1'b1);
      compare_leds(leds_o, expected_leds(`LED_SRC_AT_RESET, 8'h00, 1'b0));
      repeat (5) begin
         @(negedge dsp_clk);
         compare_bit("core_rst_o", core_rst_o, 1'b0);
         compare_bit("boot_map_o", boot_map_o, 1'b0);
      end
   endtask

   initial begin
      void'($urandom(32'h7b18_fa1b));
      por_rst    <= 1'b1;
      set_bus_i  <= '0;
      pps_i      <= 1'b0;
      rb_index_i <= '0;
      {button_i, clk_status_i, serdes_link_up_i, run_rx_i, run_tx_i} <= 5'b0;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      por_rst <= 1'b0;
      check_reset_defaults();
      write_misc_regs();
      select_led_sources();
      load_time_and_read();
      capture_pps();
      pulse_bootloader_reset();
      if (radio_ctrl_core_inst.radio_ctrl_core_assertions_inst.fail_count != 0) begin
         $display("Bound assertions reported a failure");
         end_with_failure();
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

// File: radio_ctrl_core.f
+incdir+design
design/radio_ctrl_pkg.sv
design/boot_ctrl_fsm.sv
design/vita_time_counter.sv
design/misc_settings_bank.sv
design/status_readback_mux.sv
design/radio_ctrl_core.sv
tests/radio_ctrl_core_assertions.sv
tests/radio_ctrl_core_tb.sv

// File: Makefile
TOP = radio_ctrl_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f radio_ctrl_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f radio_ctrl_core.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+10

clean:
	rm -rf obj_dir
